/* all.f */
+incdir+.
icache_pkg.sv
ibus_pkg.sv
l1_icache.sv
l2_icache.sv
ic_miss_ctrl.sv
ifetch_top.sv
tb_ifetch.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ifetch -f all.f
out=$(./obj_dir/Vtb_ifetch 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Simulation did not pass"
exit 1

/* tb_ifetch.sv */
// Top-level directed testbench that drives the fetch miss path through a burst bus model
`timescale 1ns/1ps
`default_nettype none
`include "icache_cfg.svh"

module tb_ifetch;

	localparam int TIMEOUT    = 200;
	localparam int LINE_BYTES = `IC_LINE_W / 8;
	// Memory contents are the beat address XOR this key
	localparam logic [31:0] DATA_KEY = 32'h5A3C_96E1;
	// A and B share an L1 index but not an L2 index
	localparam icache_pkg::ic_addr_t COLD_ADR = 32'h0000_0204;
	localparam icache_pkg::ic_addr_t CONF_A   = 32'h0000_1000;
	localparam icache_pkg::ic_addr_t CONF_B   = 32'h0000_1100;
	localparam icache_pkg::ic_addr_t ERR_ADR  = 32'h0000_2040;

	logic                 clk;
	logic                 rst_i;
	logic                 fetch_req_i;
	icache_pkg::ic_addr_t fetch_adr_i;
	logic                 inv_i;
	icache_pkg::ic_addr_t inv_adr_i;
	ibus_pkg::ibus_rsp_t  bus_rsp = '0;
	logic                 fetch_hit_o;
	icache_pkg::ic_line_t fetch_line_o;
	icache_pkg::ic_flt_e  fetch_flt_o;
	ibus_pkg::ibus_req_t  bus_req_o;
	logic                 idle_o;
	icache_pkg::ic_mcnt_t miss_count_o;

	// Bus model state with recent beats kept in a small ring
	integer               bus_seed   = 18;
	integer               sweep_seed = 18;
	int                   delay_left = -1;
	int                   beat_total = 0;
	int                   cyc_total  = 0;
	icache_pkg::ic_addr_t beat_adr [8];
	ibus_pkg::ibus_cti_t  beat_cti [8];
	logic                 err_en;
	icache_pkg::ic_addr_t err_adr;

	// Expected contents of both caches by line address
	icache_pkg::ic_addr_t m_l1_adr [`IC_L1_LINES];
	logic                 m_l1_vld [`IC_L1_LINES];
	icache_pkg::ic_addr_t m_l2_adr [`IC_L2_LINES];
	logic                 m_l2_vld [`IC_L2_LINES];

	ifetch_top i_ifetch_top (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_req_i  (fetch_req_i),
		.fetch_adr_i  (fetch_adr_i),
		.inv_i        (inv_i),
		.inv_adr_i    (inv_adr_i),
		.bus_rsp_i    (bus_rsp),
		.fetch_hit_o  (fetch_hit_o),
		.fetch_line_o (fetch_line_o),
		.fetch_flt_o  (fetch_flt_o),
		.bus_req_o    (bus_req_o),
		.idle_o       (idle_o),
		.miss_count_o (miss_count_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ==========================================================
	// Reference data and address slicing
	// ==========================================================

	function automatic logic [63:0] beat_data(input icache_pkg::ic_addr_t adr);
		return {adr ^ DATA_KEY, adr ^ DATA_KEY};
	endfunction

	// Beat 0 fills the low half of the line
	function automatic icache_pkg::ic_line_t ref_line(input icache_pkg::ic_addr_t base);
		return {beat_data(base + 32'd8), beat_data(base)};
	endfunction

	function automatic icache_pkg::ic_addr_t line_base(input icache_pkg::ic_addr_t adr);
		return adr & ~icache_pkg::ic_addr_t'(LINE_BYTES - 1);
	endfunction

	function automatic int l1_slot(input icache_pkg::ic_addr_t adr);
		return int'((adr / LINE_BYTES) % `IC_L1_LINES);
	endfunction

	function automatic int l2_slot(input icache_pkg::ic_addr_t adr);
		return int'((adr / LINE_BYTES) % `IC_L2_LINES);
	endfunction

	// ==========================================================
	// Bus memory model
	// ==========================================================

	always @(negedge clk) begin
		bus_rsp.ack = 1'b0;
		bus_rsp.err = 1'b0;
		if (bus_req_o.cyc) begin
			cyc_total = cyc_total + 1;
		end
		if (bus_req_o.cyc && bus_req_o.stb) begin
			// Draw a wait of zero to three cycles for each new beat
			if (delay_left < 0) begin
				delay_left = $random(bus_seed) & 3;
			end
			if (delay_left == 0) begin
				// A line fill reads every byte lane
				expect_equal("bus_req_o.sel", 128'(bus_req_o.sel), 128'(8'hFF));
				beat_adr[beat_total % 8] = bus_req_o.adr;
				beat_cti[beat_total % 8] = bus_req_o.cti;
				beat_total = beat_total + 1;
				if (err_en && bus_req_o.adr == err_adr) begin
					bus_rsp.err = 1'b1;
				end else begin
					bus_rsp.ack = 1'b1;
					bus_rsp.dat = beat_data(bus_req_o.adr);
				end
				delay_left = -1;
			end else begin
				delay_left = delay_left - 1;
			end
		end
	end

	// ==========================================================
	// Check and wait helpers
	// ==========================================================

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "Stopped at the first failing check");
	endtask

	task automatic expect_equal(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else
			stop_run($sformatf("[ERROR] %t: %s is %0h, expected %0h", $time, name, got, exp));
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (!idle_o && n < TIMEOUT) begin
			@(negedge clk);
			n = n + 1;
		end
		assert (idle_o) else stop_run("Timeout waiting for the controller to return to idle");
	endtask

	// Fetch one address and check bus use and miss count against the cache model
	task automatic fetch_line(input icache_pkg::ic_addr_t adr,
		output icache_pkg::ic_line_t line, output icache_pkg::ic_flt_e flt);
		icache_pkg::ic_addr_t base;
		icache_pkg::ic_mcnt_t cnt0;
		int                   cyc0;
		int                   s1;
		int                   s2;
		int                   n;
		logic                 l1_in;
		logic                 l2_in;
		logic                 exp_bus;
		base    = line_base(adr);
		s1      = l1_slot(base);
		s2      = l2_slot(base);
		l1_in   = m_l1_vld[s1] && m_l1_adr[s1] == base;
		l2_in   = m_l2_vld[s2] && m_l2_adr[s2] == base;
		exp_bus = !l1_in && !l2_in;
		cnt0    = miss_count_o;
		cyc0    = cyc_total;
		@(negedge clk);
		fetch_req_i = 1'b1;
		fetch_adr_i = adr;
		n = 0;
		// Hold the request until the L1 answers
		do begin
			@(negedge clk);
			n = n + 1;
		end while (!fetch_hit_o && n < TIMEOUT);
		assert (fetch_hit_o) else
			stop_run($sformatf("Timeout waiting for a fetch hit at address %0h", adr));
		line        = fetch_line_o;
		flt         = fetch_flt_o;
		fetch_req_i = 1'b0;
		wait_idle();
		expect_equal("bus_req_o.cyc seen", 128'(cyc_total != cyc0), 128'(exp_bus));
		expect_equal("miss_count_o", 128'(miss_count_o), 128'(cnt0 + 40'(exp_bus)));
		// L2 keeps only lines that came from the bus without error
		if (!l1_in) begin
			if (exp_bus && !(err_en && err_adr == base)) begin
				m_l2_vld[s2] = 1'b1;
				m_l2_adr[s2] = base;
			end
			m_l1_vld[s1] = 1'b1;
			m_l1_adr[s1] = base;
		end
	endtask

	// Pulse an invalidate and wait until the line stops hitting
	task automatic invalidate_line(input icache_pkg::ic_addr_t adr);
		int n;
		@(negedge clk);
		fetch_adr_i = adr;
		inv_i       = 1'b1;
		inv_adr_i   = adr;
		@(negedge clk);
		inv_i = 1'b0;
		n = 0;
		while (fetch_hit_o && n < TIMEOUT) begin
			@(negedge clk);
			n = n + 1;
		end
		assert (!fetch_hit_o) else stop_run("Invalidated line still hits in the L1");
		if (m_l1_adr[l1_slot(adr)] == line_base(adr)) begin
			m_l1_vld[l1_slot(adr)] = 1'b0;
		end
	endtask

	// ==========================================================
	// Tests
	// ==========================================================

	task automatic test_reset();
		expect_equal("idle_o", 128'(idle_o), 128'(1'b1));
		expect_equal("bus_req_o.cyc", 128'(bus_req_o.cyc), 128'(1'b0));
		expect_equal("miss_count_o", 128'(miss_count_o), 128'(0));
	endtask

	task automatic test_cold_miss();
		icache_pkg::ic_line_t line;
		icache_pkg::ic_flt_e  flt;
		icache_pkg::ic_mcnt_t cnt0;
		int                   b0;
		cnt0 = miss_count_o;
		b0   = beat_total;
		fetch_line(COLD_ADR, line, flt);
		expect_equal("bus beat count", 128'(beat_total - b0), 128'(2));
		expect_equal("bus_req_o.adr beat 0", 128'(beat_adr[b0 % 8]), 128'(line_base(COLD_ADR)));
		expect_equal("bus_req_o.adr beat 1", 128'(beat_adr[(b0 + 1) % 8]),
			128'(line_base(COLD_ADR) + 32'd8));
		expect_equal("bus_req_o.cti beat 0", 128'(beat_cti[b0 % 8]),
			128'(ibus_pkg::IBUS_CTI_INCR));
		expect_equal("bus_req_o.cti beat 1", 128'(beat_cti[(b0 + 1) % 8]),
			128'(ibus_pkg::IBUS_CTI_END));
		expect_equal("fetch_line_o", line, ref_line(line_base(COLD_ADR)));
		expect_equal("fetch_flt_o", 128'(flt), 128'(icache_pkg::IC_FLT_NONE));
		expect_equal("miss_count_o", 128'(miss_count_o), 128'(cnt0 + 40'd1));
	endtask

	// Line dropped from the L1 comes back from the L2
	task automatic test_l2_refill();
		icache_pkg::ic_line_t line;
		icache_pkg::ic_flt_e  flt;
		icache_pkg::ic_mcnt_t cnt0;
		int                   c0;
		invalidate_line(COLD_ADR);
		cnt0 = miss_count_o;
		c0   = cyc_total;
		fetch_line(COLD_ADR, line, flt);
		expect_equal("bus_req_o.cyc seen", 128'(cyc_total != c0), 128'(1'b0));
		expect_equal("fetch_line_o", line, ref_line(line_base(COLD_ADR)));
		expect_equal("miss_count_o", 128'(miss_count_o), 128'(cnt0));
	endtask

	task automatic test_l1_conflict();
		icache_pkg::ic_line_t line;
		icache_pkg::ic_flt_e  flt;
		int                   c0;
		fetch_line(CONF_A, line, flt);
		expect_equal("fetch_line_o", line, ref_line(CONF_A));
		fetch_line(CONF_B, line, flt);
		expect_equal("fetch_line_o", line, ref_line(CONF_B));
		// B evicted A from the L1 but the L2 still holds it
		c0 = cyc_total;
		fetch_line(CONF_A, line, flt);
		expect_equal("bus_req_o.cyc seen", 128'(cyc_total != c0), 128'(1'b0));
		expect_equal("fetch_line_o", line, ref_line(CONF_A));
	endtask

	task automatic test_bus_error();
		icache_pkg::ic_line_t line;
		icache_pkg::ic_flt_e  flt;
		icache_pkg::ic_mcnt_t cnt0;
		int                   c0;
		err_en  = 1'b1;
		err_adr = ERR_ADR;
		cnt0    = miss_count_o;
		fetch_line(ERR_ADR, line, flt);
		expect_equal("fetch_line_o", line, `IC_NOP_WORD);
		expect_equal("fetch_flt_o", 128'(flt), 128'(icache_pkg::IC_FLT_BUS));
		expect_equal("miss_count_o", 128'(miss_count_o), 128'(cnt0 + 40'd1));
		err_en = 1'b0;
		// Faulted line never reached the L2 so the refetch goes out again
		invalidate_line(ERR_ADR);
		c0 = cyc_total;
		fetch_line(ERR_ADR, line, flt);
		expect_equal("bus_req_o.cyc seen", 128'(cyc_total != c0), 128'(1'b1));
		expect_equal("fetch_line_o", line, ref_line(ERR_ADR));
		expect_equal("fetch_flt_o", 128'(flt), 128'(icache_pkg::IC_FLT_NONE));
	endtask

	// Small address window so both L1 and L2 hits happen
	task automatic test_random_sweep();
		icache_pkg::ic_line_t line;
		icache_pkg::ic_flt_e  flt;
		icache_pkg::ic_addr_t adr;
		int                   k;
		for (k = 0; k < 40; k = k + 1) begin
			adr = icache_pkg::ic_addr_t'($random(sweep_seed)) & 32'h0000_07FC;
			fetch_line(adr, line, flt);
			expect_equal("fetch_line_o", line, ref_line(line_base(adr)));
			expect_equal("fetch_flt_o", 128'(flt), 128'(icache_pkg::IC_FLT_NONE));
		end
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial begin
		int i;
		$timeformat(-9, 0, " ns", 10);
		rst_i       = 1'b1;
		fetch_req_i = 1'b0;
		fetch_adr_i = '0;
		inv_i       = 1'b0;
		inv_adr_i   = '0;
		err_en      = 1'b0;
		err_adr     = '0;
		for (i = 0; i < `IC_L1_LINES; i = i + 1) begin
			m_l1_vld[i] = 1'b0;
			m_l1_adr[i] = '0;
		end
		for (i = 0; i < `IC_L2_LINES; i = i + 1) begin
			m_l2_vld[i] = 1'b0;
			m_l2_adr[i] = '0;
		end
		repeat (8) @(negedge clk);
		rst_i = 1'b0;
		test_reset();
		test_cold_miss();
		test_l2_refill();
		test_l1_conflict();
		test_bus_error();
		test_random_sweep();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* ifetch_top.sv */
// Fetch miss path top level: joins the L1, the L2 and the miss controller to fetch and bus ports
`timescale 1ns/1ps
`default_nettype none

module ifetch_top (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire                       fetch_req_i,
	input  wire icache_pkg::ic_addr_t fetch_adr_i,
	input  wire                       inv_i,
	input  wire icache_pkg::ic_addr_t inv_adr_i,
	input  wire ibus_pkg::ibus_rsp_t  bus_rsp_i,
	output logic                      fetch_hit_o,
	output icache_pkg::ic_line_t      fetch_line_o,
	output icache_pkg::ic_flt_e       fetch_flt_o,
	output ibus_pkg::ibus_req_t       bus_req_o,
	output logic                      idle_o,
	output icache_pkg::ic_mcnt_t      miss_count_o
);

	// Controller to caches
	icache_pkg::ic_fill_t l1_fill;
	icache_pkg::ic_addr_t l2_adr;
	logic                 l2_ld;
	icache_pkg::ic_line_t l2_ld_line;
	// Caches to controller
	logic                 l2_hit;
	icache_pkg::ic_line_t l2_line;

	l1_icache i_l1_icache (
		.clk        (clk),
		.rst_i      (rst_i),
		.look_adr_i (fetch_adr_i),
		.fill_i     (l1_fill),
		.hit_o      (fetch_hit_o),
		.line_o     (fetch_line_o),
		.flt_o      (fetch_flt_o)
	);

	// The L2 is looked up and loaded at the same miss address
	l2_icache i_l2_icache (
		.clk       (clk),
		.rst_i     (rst_i),
		.adr_i     (l2_adr),
		.ld_i      (l2_ld),
		.ld_adr_i  (l2_adr),
		.ld_line_i (l2_ld_line),
		.hit_o     (l2_hit),
		.line_o    (l2_line)
	);

	ic_miss_ctrl i_ic_miss_ctrl (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_req_i  (fetch_req_i),
		.fetch_adr_i  (fetch_adr_i),
		.l1_hit_i     (fetch_hit_o),
		.inv_i        (inv_i),
		.inv_adr_i    (inv_adr_i),
		.l2_hit_i     (l2_hit),
		.l2_line_i    (l2_line),
		.bus_rsp_i    (bus_rsp_i),
		.l1_fill_o    (l1_fill),
		.l2_adr_o     (l2_adr),
		.l2_ld_o      (l2_ld),
		.l2_ld_line_o (l2_ld_line),
		.bus_req_o    (bus_req_o),
		.idle_o       (idle_o),
		.miss_count_o (miss_count_o)
	);

endmodule

`default_nettype wire

/* ic_miss_ctrl.sv */
// Miss controller: resolves L1 misses through the L2 or a two-beat bus burst, and invalidates
`timescale 1ns/1ps
`default_nettype none
`include "icache_cfg.svh"

module ic_miss_ctrl (
	input  wire                         clk,
	input  wire                         rst_i,
	input  wire                         fetch_req_i,
	input  wire icache_pkg::ic_addr_t   fetch_adr_i,
	input  wire                         l1_hit_i,
	input  wire                         inv_i,
	input  wire icache_pkg::ic_addr_t   inv_adr_i,
	input  wire                         l2_hit_i,
	input  wire icache_pkg::ic_line_t   l2_line_i,
	input  wire ibus_pkg::ibus_rsp_t    bus_rsp_i,
	output icache_pkg::ic_fill_t        l1_fill_o,
	output icache_pkg::ic_addr_t        l2_adr_o,
	output logic                        l2_ld_o,
	output icache_pkg::ic_line_t        l2_ld_line_o,
	output ibus_pkg::ibus_req_t         bus_req_o,
	output logic                        idle_o,
	output icache_pkg::ic_mcnt_t        miss_count_o
);

	// Clears the byte offset within a line
	localparam icache_pkg::ic_addr_t LINE_MASK = ~icache_pkg::ic_addr_t'(`IC_LINE_W / 8 - 1);
	localparam logic [2:0] L2_LAST = 3'(`IC_L2_READ_LAT - 1);
	localparam logic [2:0] WR_LAST = 3'(`IC_L1_WRITE_LAT - 1);
	localparam int HALF_W = `IC_LINE_W / 2;

	icache_pkg::ic_state_e state_q;
	logic [2:0]            cnt_q;
	// Second beat of the burst is next
	logic                  beat_q;
	logic                  inv_pend_q;
	icache_pkg::ic_addr_t  inv_adr_q;
	icache_pkg::ic_addr_t  miss_adr_q;
	icache_pkg::ic_line_t  line_buf_q;
	icache_pkg::ic_flt_e   flt_q;

	// The L2 is probed and loaded at the line being missed
	assign l2_adr_o     = miss_adr_q;
	assign l2_ld_line_o = line_buf_q;

	// ==========================================================
	// Miss state machine
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q       <= icache_pkg::IC_ST_IDLE;
			cnt_q         <= '0;
			beat_q        <= 1'b0;
			inv_pend_q    <= 1'b0;
			idle_o        <= 1'b1;
			miss_count_o  <= '0;
			l1_fill_o.wr  <= 1'b0;
			l1_fill_o.inv <= 1'b0;
			l2_ld_o       <= 1'b0;
			bus_req_o.cyc <= 1'b0;
			bus_req_o.stb <= 1'b0;
		end else begin
			// Fill and load strobes last one cycle
			l1_fill_o.wr  <= 1'b0;
			l1_fill_o.inv <= 1'b0;
			l2_ld_o       <= 1'b0;

			case (state_q)
			icache_pkg::IC_ST_IDLE: begin
				cnt_q <= '0;
				// A pending invalidate goes first, the miss is seen again next cycle
				if (inv_pend_q) begin
					l1_fill_o.inv <= 1'b1;
					l1_fill_o.adr <= inv_adr_q;
					inv_pend_q    <= 1'b0;
				end else if (fetch_req_i && !l1_hit_i) begin
					miss_adr_q <= fetch_adr_i & LINE_MASK;
					idle_o     <= 1'b0;
					state_q    <= icache_pkg::IC_ST_L2_WAIT;
				end
			end

			icache_pkg::IC_ST_L2_WAIT: begin
				cnt_q <= cnt_q + 3'd1;
				if (cnt_q == L2_LAST) begin
					cnt_q <= '0;
					if (l2_hit_i) begin
						// Copy the L2 line straight into the L1
						l1_fill_o.wr   <= 1'b1;
						l1_fill_o.adr  <= miss_adr_q;
						l1_fill_o.line <= l2_line_i;
						l1_fill_o.flt  <= icache_pkg::IC_FLT_NONE;
						state_q        <= icache_pkg::IC_ST_WRITE_WAIT;
					end else begin
						// Both levels missed, start the burst
						bus_req_o.cyc <= 1'b1;
						bus_req_o.stb <= 1'b1;
						bus_req_o.cti <= ibus_pkg::IBUS_CTI_INCR;
						bus_req_o.sel <= '1;
						bus_req_o.adr <= miss_adr_q;
						beat_q        <= 1'b0;
						state_q       <= icache_pkg::IC_ST_BUS_ACK;
					end
				end
			end

			icache_pkg::IC_ST_BUS_ACK: begin
				if (bus_rsp_i.err) begin
					// Error ends the cycle at once, the line becomes no-ops
					line_buf_q    <= `IC_NOP_WORD;
					flt_q         <= icache_pkg::IC_FLT_BUS;
					bus_req_o.cyc <= 1'b0;
					bus_req_o.stb <= 1'b0;
					state_q       <= icache_pkg::IC_ST_LOAD_DONE;
				end else if (bus_rsp_i.ack) begin
					if (!beat_q) begin
						line_buf_q[HALF_W-1:0] <= bus_rsp_i.dat;
						bus_req_o.adr          <= bus_req_o.adr + 'd8;
						bus_req_o.cti          <= ibus_pkg::IBUS_CTI_END;
						beat_q                 <= 1'b1;
					end else begin
						line_buf_q[`IC_LINE_W-1:HALF_W] <= bus_rsp_i.dat;
						flt_q         <= icache_pkg::IC_FLT_NONE;
						bus_req_o.cyc <= 1'b0;
						bus_req_o.stb <= 1'b0;
						state_q       <= icache_pkg::IC_ST_LOAD_DONE;
					end
				end
			end

			icache_pkg::IC_ST_LOAD_DONE: begin
				// Write the assembled line, L2 only keeps good data
				l1_fill_o.wr   <= 1'b1;
				l1_fill_o.adr  <= miss_adr_q;
				l1_fill_o.line <= line_buf_q;
				l1_fill_o.flt  <= flt_q;
				l2_ld_o        <= (flt_q == icache_pkg::IC_FLT_NONE);
				miss_count_o   <= miss_count_o + 40'd1;
				cnt_q          <= '0;
				state_q        <= icache_pkg::IC_ST_WRITE_WAIT;
			end

			icache_pkg::IC_ST_WRITE_WAIT: begin
				// Let the L1 write settle before taking new misses
				cnt_q <= cnt_q + 3'd1;
				if (cnt_q == WR_LAST) begin
					cnt_q   <= '0;
					idle_o  <= 1'b1;
					state_q <= icache_pkg::IC_ST_IDLE;
				end
			end

			default: begin
				idle_o  <= 1'b1;
				state_q <= icache_pkg::IC_ST_IDLE;
			end
			endcase

			// Latch invalidates in any state, newest request wins
			if (inv_i) begin
				inv_pend_q <= 1'b1;
				inv_adr_q  <= inv_adr_i & LINE_MASK;
			end
		end
	end

	// ==========================================================
	// Checks
	// ==========================================================

	// Strobe only inside a bus cycle
	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i)
		bus_req_o.stb |-> bus_req_o.cyc);

	// The L1 port takes a write or an invalidate, never both
	a_fill_excl: assert property (@(posedge clk) disable iff (rst_i)
		!(l1_fill_o.wr && l1_fill_o.inv));

endmodule

`default_nettype wire

/* l2_icache.sv */
// Direct-mapped L2 instruction cache with registered lookup and line load for the fetch top level
`timescale 1ns/1ps
`default_nettype none
`include "icache_cfg.svh"

module l2_icache (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire icache_pkg::ic_addr_t adr_i,
	input  wire                       ld_i,
	input  wire icache_pkg::ic_addr_t ld_adr_i,
	input  wire icache_pkg::ic_line_t ld_line_i,
	output logic                      hit_o,
	output icache_pkg::ic_line_t      line_o
);

	logic [`IC_L2_LINES-1:0] valid_q;
	icache_pkg::ic_l2_tag_t  tag_q  [`IC_L2_LINES];
	icache_pkg::ic_line_t    data_q [`IC_L2_LINES];

	icache_pkg::ic_l2_idx_t  rd_idx;
	icache_pkg::ic_l2_idx_t  ld_idx;

	assign rd_idx = icache_pkg::l2_idx(adr_i);
	assign ld_idx = icache_pkg::l2_idx(ld_adr_i);

	// ==========================================================
	// Registered lookup with the result one cycle after the address
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
			hit_o   <= 1'b0;
		end else begin
			hit_o <= valid_q[rd_idx] && (tag_q[rd_idx] == icache_pkg::l2_tag(adr_i));
			if (ld_i) begin
				valid_q[ld_idx] <= 1'b1;
			end
		end
	end

	// Data read and line load
	always_ff @(posedge clk) begin
		line_o <= data_q[rd_idx];
		if (ld_i) begin
			tag_q[ld_idx]  <= icache_pkg::l2_tag(ld_adr_i);
			data_q[ld_idx] <= ld_line_i;
		end
	end

	// Reset clears every valid bit so the first compare after reset cannot hit
	a_no_hit_after_rst: assert property (@(posedge clk)
		$past(rst_i) && !rst_i |=> !hit_o);

endmodule

`default_nettype wire

/* l1_icache.sv */
// L1 instruction cache: direct-mapped arrays with same-cycle lookup, fill and invalidate ports
`timescale 1ns/1ps
`default_nettype none
`include "icache_cfg.svh"

module l1_icache (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire icache_pkg::ic_addr_t look_adr_i,
	input  wire icache_pkg::ic_fill_t fill_i,
	output logic                      hit_o,
	output icache_pkg::ic_line_t      line_o,
	output icache_pkg::ic_flt_e       flt_o
);

	logic [`IC_L1_LINES-1:0] valid_q;
	icache_pkg::ic_l1_tag_t  tag_q  [`IC_L1_LINES];
	icache_pkg::ic_line_t    data_q [`IC_L1_LINES];
	icache_pkg::ic_flt_e     flt_q  [`IC_L1_LINES];

	icache_pkg::ic_l1_idx_t  look_idx;
	icache_pkg::ic_l1_tag_t  look_tag;
	icache_pkg::ic_l1_idx_t  fill_idx;
	icache_pkg::ic_l1_tag_t  fill_tag;

	assign look_idx = icache_pkg::l1_idx(look_adr_i);
	assign look_tag = icache_pkg::l1_tag(look_adr_i);
	assign fill_idx = icache_pkg::l1_idx(fill_i.adr);
	assign fill_tag = icache_pkg::l1_tag(fill_i.adr);

	// ==========================================================
	// Lookup, answered in the same cycle
	// ==========================================================

	assign hit_o  = valid_q[look_idx] && (tag_q[look_idx] == look_tag);
	assign line_o = data_q[look_idx];
	assign flt_o  = flt_q[look_idx];

	// ==========================================================
	// Valid bits
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (fill_i.wr) begin
			valid_q[fill_idx] <= 1'b1;
		end else if (fill_i.inv && tag_q[fill_idx] == fill_tag) begin
			// Only drop the line if it still holds that address
			valid_q[fill_idx] <= 1'b0;
		end
	end

	// Tag, data and fault arrays
	always_ff @(posedge clk) begin
		if (fill_i.wr) begin
			tag_q[fill_idx]  <= fill_tag;
			data_q[fill_idx] <= fill_i.line;
			flt_q[fill_idx]  <= fill_i.flt;
		end
	end

endmodule

`default_nettype wire

/* ibus_pkg.sv */
// Bus type package for the 64-bit burst bus between the miss controller and memory
`default_nettype none
`include "icache_cfg.svh"

package ibus_pkg;

	typedef logic [`IC_ADDR_W-1:0] ibus_adr_t;
	typedef logic [63:0]           ibus_dat_t;
	typedef logic [2:0]            ibus_cti_t;
	// One byte lane select per data byte
	typedef logic [7:0]            ibus_sel_t;

	// Cycle types: incrementing burst, then last beat
	localparam ibus_cti_t IBUS_CTI_INCR = 3'b010;
	localparam ibus_cti_t IBUS_CTI_END  = 3'b111;

	// Master to slave
	typedef struct packed {
		logic      cyc;
		logic      stb;
		ibus_cti_t cti;
		ibus_sel_t sel;
		ibus_adr_t adr;
	} ibus_req_t;

	// Slave to master, ack and err are one-cycle strobes
	typedef struct packed {
		logic      ack;
		logic      err;
		ibus_dat_t dat;
	} ibus_rsp_t;

endpackage

`default_nettype wire

/* icache_pkg.sv */
// Cache type package for the fetch miss path: addresses, lines, fill records and FSM states
`default_nettype none
`include "icache_cfg.svh"

package icache_pkg;

	// Field widths derived from the cache geometry
	localparam int IC_OFS_W    = $clog2(`IC_LINE_W / 8);
	localparam int IC_L1_IDX_W = $clog2(`IC_L1_LINES);
	localparam int IC_L2_IDX_W = $clog2(`IC_L2_LINES);
	localparam int IC_L1_TAG_W = `IC_ADDR_W - IC_OFS_W - IC_L1_IDX_W;
	localparam int IC_L2_TAG_W = `IC_ADDR_W - IC_OFS_W - IC_L2_IDX_W;

	typedef logic [`IC_ADDR_W-1:0]   ic_addr_t;
	typedef logic [`IC_LINE_W-1:0]   ic_line_t;
	typedef logic [IC_L1_IDX_W-1:0]  ic_l1_idx_t;
	typedef logic [IC_L1_TAG_W-1:0]  ic_l1_tag_t;
	typedef logic [IC_L2_IDX_W-1:0]  ic_l2_idx_t;
	typedef logic [IC_L2_TAG_W-1:0]  ic_l2_tag_t;
	// Line-load counter
	typedef logic [39:0]             ic_mcnt_t;

	// Fault code stored beside each L1 line
	typedef enum logic [1:0] {
		IC_FLT_NONE = 2'd0,
		IC_FLT_BUS  = 2'd3
	} ic_flt_e;

	// Miss controller states
	typedef enum logic [2:0] {
		IC_ST_IDLE,
		IC_ST_L2_WAIT,
		IC_ST_BUS_ACK,
		IC_ST_LOAD_DONE,
		IC_ST_WRITE_WAIT
	} ic_state_e;

	// One L1 update: a line write or an invalidate
	typedef struct packed {
		logic     wr;
		logic     inv;
		ic_addr_t adr;
		ic_line_t line;
		ic_flt_e  flt;
	} ic_fill_t;

	// Address slicing for both caches
	function automatic ic_l1_idx_t l1_idx(input ic_addr_t adr);
		return adr[IC_OFS_W +: IC_L1_IDX_W];
	endfunction

	function automatic ic_l1_tag_t l1_tag(input ic_addr_t adr);
		return adr[`IC_ADDR_W-1 -: IC_L1_TAG_W];
	endfunction

	function automatic ic_l2_idx_t l2_idx(input ic_addr_t adr);
		return adr[IC_OFS_W +: IC_L2_IDX_W];
	endfunction

	function automatic ic_l2_tag_t l2_tag(input ic_addr_t adr);
		return adr[`IC_ADDR_W-1 -: IC_L2_TAG_W];
	endfunction

endpackage

`default_nettype wire

/* icache_cfg.svh */
// Cache geometry and latency macros for the fetch miss path, included by RTL and testbench
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ==========================================================
// Geometry
// ==========================================================

// Byte address width
`define IC_ADDR_W 32
// One cache line holds four 32-bit instruction words
`define IC_LINE_W 128
`define IC_L1_LINES 16
`define IC_L2_LINES 64

// ==========================================================
// Latencies and fill pattern
// ==========================================================

// Cycles between presenting an L2 lookup and using its result
`define IC_L2_READ_LAT 3
// Cycles the L1 needs before a written line may be trusted
`define IC_L1_WRITE_LAT 3
// Four no-op words, used when a bus error leaves no real data
`define IC_NOP_WORD 128'h00000013_00000013_00000013_00000013

`endif
